// File: flist.f
logic/mondo_queue_pkg.sv
logic/mondo_iob_pkg.sv
logic/queue_if.sv
logic/mondo_queue.sv
logic/mondo_capture.sv
logic/mondo_pop_fsm.sv
logic/mondo_beat_counter.sv
logic/mondo_serializer.sv
logic/mondo_rqq_top.sv
tb/tb_mondo_rqq.sv

// File: Makefile
TOP = tb_mondo_rqq
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f flist.f
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG) || exit 1

clean:
	rm -rf obj_dir $(LOG)

// File: tb/tb_mondo_rqq.sv
`timescale 1ns/1ps

module tb_mondo_rqq;

   import mondo_queue_pkg::*;
   import mondo_iob_pkg::*;

   localparam int NROWS = 16;
   localparam int BEATS = DATA_BEATS + 2;

   typedef struct packed {
      logic [ID_WIDTH-1:0] agent;
      logic [ID_WIDTH-1:0] cpu;
      logic                err;
      logic                nack;
      int                  delay;
      int                  holdoff;
      logic [AD_WIDTH-1:0] payload;
   } row_t;

   logic                       clk;
   logic                       rst_n;
   logic                       in_hdr_push;
   logic                       in_data_push;
   logic                       in_data_err;
   logic [AD_WIDTH-1:0]        in_ad;
   logic                       credit_return;
   logic                       mondo_vld;
   logic [MONDO_BUS_WIDTH-1:0] mondo_data;
   logic                       iob_ack;
   logic                       iob_nack;
   logic                       ack_vld;
   logic                       ack_rdy;
   logic                       ack_nack;
   logic [ID_WIDTH-1:0]        ack_agent_id;
   logic [ID_WIDTH-1:0]        ack_cpu_id;

   row_t        rows [NROWS];
   logic [31:0] lfsr_state;
   int          credits;
   int          credit_pulses;
   int          vld_cycles;
   int          checks;
   int          errors;
   int          watchdog_cycles;

   mondo_rqq_top uut (
      .clk           (clk),
      .rst_n         (rst_n),
      .in_hdr_push   (in_hdr_push),
      .in_data_push  (in_data_push),
      .in_data_err   (in_data_err),
      .in_ad         (in_ad),
      .credit_return (credit_return),
      .mondo_vld     (mondo_vld),
      .mondo_data    (mondo_data),
      .iob_ack       (iob_ack),
      .iob_nack      (iob_nack),
      .ack_vld       (ack_vld),
      .ack_rdy       (ack_rdy),
      .ack_nack      (ack_nack),
      .ack_agent_id  (ack_agent_id),
      .ack_cpu_id    (ack_cpu_id)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic compare(input string name, input logic [AD_WIDTH-1:0] expected,
                          input logic [AD_WIDTH-1:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      end
   endtask

   task automatic load_row(input int idx, input int agent, input int cpu, input bit err,
                           input bit nack, input int delay, input int holdoff);
      rows[idx].agent   = ID_WIDTH'(agent);
      rows[idx].cpu     = ID_WIDTH'(cpu);
      rows[idx].err     = err;
      rows[idx].nack    = nack;
      rows[idx].delay   = delay;
      rows[idx].holdoff = holdoff;
      for (int b = 0; b < AD_WIDTH; b++) begin
         lfsr_state           = lfsr_next(lfsr_state);
         rows[idx].payload[b] = lfsr_state[0];
      end
   endtask

   // CPU id, agent id, then payload from the top byte down
   function automatic logic [MONDO_BUS_WIDTH-1:0] expected_beat(input int r, input int b);
      if (b == 0)
         return MONDO_BUS_WIDTH'(rows[r].cpu);
      if (b == 1)
         return MONDO_BUS_WIDTH'(rows[r].agent);
      return rows[r].payload[(BEATS - 1 - b) * MONDO_BUS_WIDTH +: MONDO_BUS_WIDTH];
   endfunction

   // Credits come back and mondo cycles are counted mid-cycle
   always @(negedge clk) begin
      if (rst_n) begin
         if (credit_return === 1'b1) begin
            credits++;
            credit_pulses++;
            compare("sender_credits_max", 1, credits <= MRQQ_DEPTH);
         end
         if (mondo_vld === 1'b1)
            vld_cycles++;
      end
   end

   task automatic send_requests();
      logic [AD_WIDTH-1:0] hdr;
      for (int r = 0; r < NROWS; r++) begin
         while (credits == 0) begin
            @(posedge clk);
            #1;
         end
         hdr = '0;
         hdr[AD_AGENT_ID_LO +: ID_WIDTH] = rows[r].agent;
         hdr[AD_CPU_ID_LO +: ID_WIDTH]   = rows[r].cpu;
         in_hdr_push = 1'b1;
         in_ad       = hdr;
         @(posedge clk);
         #1;
         in_hdr_push  = 1'b0;
         in_data_push = 1'b1;
         in_data_err  = rows[r].err;
         in_ad        = rows[r].payload;
         credits--;
         @(posedge clk);
         #1;
         in_data_push = 1'b0;
         in_data_err  = 1'b0;
         in_ad        = '0;
      end
   endtask

   // Beat stream of each sent row and the bridge answer after its delay
   task automatic answer_bridge();
      for (int r = 0; r < NROWS; r++) begin
         if (!rows[r].err) begin
            @(negedge clk);
            while (mondo_vld !== 1'b1)
               @(negedge clk);
            for (int b = 0; b < BEATS; b++) begin
               if (b > 0)
                  @(negedge clk);
               compare("mondo_vld", 1, mondo_vld);
               compare("mondo_data", expected_beat(r, b), mondo_data);
               compare("credit_return", b == BEATS - 2, credit_return);
            end
            @(negedge clk);
            compare("mondo_vld", 0, mondo_vld);
            repeat (rows[r].delay) @(posedge clk);
            @(posedge clk);
            #1;
            iob_ack  = !rows[r].nack;
            iob_nack = rows[r].nack;
            @(posedge clk);
            #1;
            iob_ack  = 1'b0;
            iob_nack = 1'b0;
         end
      end
   endtask

   task automatic drain_results();
      int err_before;
      for (int r = 0; r < NROWS; r++) begin
         err_before = errors;
         repeat (rows[r].holdoff) begin
            @(posedge clk);
            #1;
         end
         ack_rdy = 1'b1;
         @(negedge clk);
         while (ack_vld !== 1'b1)
            @(negedge clk);
         compare("ack_nack", rows[r].err | rows[r].nack, ack_nack);
         compare("ack_agent_id", rows[r].agent, ack_agent_id);
         compare("ack_cpu_id", rows[r].cpu, ack_cpu_id);
         @(posedge clk);
         #1;
         ack_rdy = 1'b0;
         $display("row %0d agent %0d cpu %0d %s: %s", r, rows[r].agent, rows[r].cpu,
                  rows[r].err ? "error entry" : "sent", errors == err_before ? "ok" : "mismatch");
      end
   endtask

   task automatic run_watchdog();
      #(watchdog_cycles * 10);
      $display("timeout: the regression did not finish within %0d cycles", watchdog_cycles);
      $display("Regression failed");
      $finish;
   endtask

   initial begin
      int nsent;
      in_hdr_push     = 1'b0;
      in_data_push    = 1'b0;
      in_data_err     = 1'b0;
      in_ad           = '0;
      iob_ack         = 1'b0;
      iob_nack        = 1'b0;
      ack_rdy         = 1'b0;
      rst_n           = 1'b0;
      lfsr_state      = 32'h1e77;
      credits         = MRQQ_DEPTH;
      credit_pulses   = 0;
      vld_cycles      = 0;
      checks          = 0;
      errors          = 0;
      nsent           = 0;
      watchdog_cycles = 200;

      // Agent, CPU, err, nack, response delay, ack_rdy hold-off
      load_row(0, 3, 17, 0, 0, 2, 0);
      load_row(1, 31, 0, 0, 1, 0, 3);
      load_row(2, 12, 5, 0, 0, 5, 250);
      load_row(3, 7, 30, 1, 0, 0, 0);
      load_row(4, 1, 1, 0, 1, 1, 0);
      load_row(5, 20, 9, 0, 0, 3, 0);
      load_row(6, 0, 31, 0, 0, 8, 0);
      load_row(7, 9, 14, 1, 0, 0, 0);
      load_row(8, 10, 15, 1, 1, 0, 0);
      load_row(9, 25, 2, 0, 1, 2, 0);
      load_row(10, 16, 16, 0, 0, 0, 2);
      load_row(11, 5, 27, 0, 0, 4, 0);
      load_row(12, 30, 8, 0, 1, 1, 0);
      load_row(13, 11, 19, 1, 0, 0, 0);
      load_row(14, 2, 23, 0, 0, 6, 1);
      load_row(15, 18, 4, 0, 1, 0, 0);

      for (int r = 0; r < NROWS; r++) begin
         watchdog_cycles += 40 + rows[r].delay + rows[r].holdoff;
         if (!rows[r].err)
            nsent++;
      end
      fork
         run_watchdog();
      join_none

      repeat (10) begin
         @(negedge clk);
         compare("mondo_vld", 0, mondo_vld);
         compare("credit_return", 0, credit_return);
         compare("ack_vld", 0, ack_vld);
      end
      @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      compare("mondo_vld", 0, mondo_vld);
      compare("credit_return", 0, credit_return);
      compare("ack_vld", 0, ack_vld);
      $display("reset: %s", errors == 0 ? "ok" : "mismatch");

      @(posedge clk);
      #1;
      fork
         send_requests();
         answer_bridge();
         drain_results();
      join

      repeat (5) @(negedge clk);
      compare("credit_pulses", NROWS, credit_pulses);
      compare("sender_credits", MRQQ_DEPTH, credits);
      compare("mondo_vld_cycles", nsent * BEATS, vld_cycles);
      compare("ack_vld", 0, ack_vld);
      $display("credits and bus cycles: %0d pulses, %0d credits, %0d mondo cycles",
               credit_pulses, credits, vld_cycles);
      $display("rows %0d, checks %0d, errors %0d", NROWS, checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// File: logic/mondo_rqq_top.sv
`timescale 1ns/1ps

module mondo_rqq_top (
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  logic                                      in_hdr_push,
   input  logic                                      in_data_push,
   input  logic                                      in_data_err,
   input  logic [mondo_queue_pkg::AD_WIDTH-1:0]      in_ad,
   output logic                                      credit_return,
   output logic                                      mondo_vld,
   output logic [mondo_iob_pkg::MONDO_BUS_WIDTH-1:0] mondo_data,
   input  logic                                      iob_ack,
   input  logic                                      iob_nack,
   output logic                                      ack_vld,
   input  logic                                      ack_rdy,
   output logic                                      ack_nack,
   output logic [mondo_queue_pkg::ID_WIDTH-1:0]      ack_agent_id,
   output logic [mondo_queue_pkg::ID_WIDTH-1:0]      ack_cpu_id
);

   import mondo_queue_pkg::*;
   import mondo_iob_pkg::*;

   queue_if #(.T(mrqq_entry_t)) req_if ();
   queue_if #(.T(makq_entry_t)) ack_if ();

   logic       cnt_clear;
   logic       cnt_advance;
   logic       last_beat;
   logic [3:0] beat_idx;
   beat_sel_t  beat_sel;

   mondo_capture u_capture (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_hdr_push  (in_hdr_push),
      .in_data_push (in_data_push),
      .in_data_err  (in_data_err),
      .in_ad        (in_ad),
      .req          (req_if.producer)
   );

   mondo_queue #(.T(mrqq_entry_t), .DEPTH(MRQQ_DEPTH)) req_q (
      .clk   (clk),
      .rst_n (rst_n),
      .q     (req_if.storage)
   );

   mondo_pop_fsm u_pop_fsm (
      .clk           (clk),
      .rst_n         (rst_n),
      .iob_ack       (iob_ack),
      .iob_nack      (iob_nack),
      .req           (req_if.consumer),
      .ack           (ack_if.producer),
      .last_beat     (last_beat),
      .cnt_clear     (cnt_clear),
      .cnt_advance   (cnt_advance),
      .beat_sel      (beat_sel),
      .credit_return (credit_return)
   );

   mondo_beat_counter u_beat_counter (
      .clk       (clk),
      .rst_n     (rst_n),
      .clear     (cnt_clear),
      .advance   (cnt_advance),
      .beat_idx  (beat_idx),
      .last_beat (last_beat)
   );

   mondo_serializer u_serializer (
      .clk        (clk),
      .rst_n      (rst_n),
      .beat_sel   (beat_sel),
      .entry      (req_if.data),
      .beat_idx   (beat_idx),
      .mondo_vld  (mondo_vld),
      .mondo_data (mondo_data)
   );

   mondo_queue #(.T(makq_entry_t), .DEPTH(MAKQ_DEPTH)) ack_q (
      .clk   (clk),
      .rst_n (rst_n),
      .q     (ack_if.storage)
   );

   // Result drain, valid/ready toward the outside
   assign ack_vld      = ack_if.valid;
   assign ack_if.pop   = ack_vld && ack_rdy;
   assign ack_nack     = ack_if.data.nack;
   assign ack_agent_id = ack_if.data.agent_id;
   assign ack_cpu_id   = ack_if.data.cpu_id;

endmodule

// File: logic/mondo_serializer.sv
`timescale 1ns/1ps

module mondo_serializer (
   input  logic                                        clk,
   input  logic                                        rst_n,
   input  mondo_iob_pkg::beat_sel_t                    beat_sel,
   input  mondo_queue_pkg::mrqq_entry_t                entry,
   input  logic [3:0]                                  beat_idx,
   output logic                                        mondo_vld,
   output logic [mondo_iob_pkg::MONDO_BUS_WIDTH-1:0]   mondo_data
);

   import mondo_iob_pkg::*;

   logic [MONDO_BUS_WIDTH-1:0] next_data;
   int                         byte_pos;

   // Payload goes out most significant byte first
   assign byte_pos = DATA_BEATS - 1 - int'(beat_idx);

   always_comb begin
      case (beat_sel)
         BEAT_CPU:   next_data = MONDO_BUS_WIDTH'(entry.cpu_id);
         BEAT_AGENT: next_data = MONDO_BUS_WIDTH'(entry.agent_id);
         BEAT_DATA:  next_data = entry.data[byte_pos*MONDO_BUS_WIDTH +: MONDO_BUS_WIDTH];
         default:    next_data = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mondo_vld <= 1'b0;
      end else begin
         mondo_vld <= (beat_sel != BEAT_NONE);
      end
   end

   // Bus byte, qualified by mondo_vld
   always_ff @(posedge clk) begin
      mondo_data <= next_data;
   end

endmodule

// File: logic/mondo_beat_counter.sv
`timescale 1ns/1ps

module mondo_beat_counter (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       clear,
   input  logic       advance,
   output logic [3:0] beat_idx,
   output logic       last_beat
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         beat_idx <= '0;
      end else if (clear) begin
         beat_idx <= '0;
      end else if (advance) begin
         beat_idx <= beat_idx + 4'd1;
      end
   end

   // Byte 15 is the final payload beat
   assign last_beat = &beat_idx;

   // FSM has to stop advancing at the last beat
   assert property (@(posedge clk) disable iff (!rst_n)
      advance |-> !last_beat)
      else $error("%m: data beat counter wrapped");

endmodule

// File: logic/mondo_pop_fsm.sv
`timescale 1ns/1ps

module mondo_pop_fsm (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     iob_ack,
   input  logic                     iob_nack,
   queue_if.consumer                req,
   queue_if.producer                ack,
   input  logic                     last_beat,
   output logic                     cnt_clear,
   output logic                     cnt_advance,
   output mondo_iob_pkg::beat_sel_t beat_sel,
   output logic                     credit_return
);

   import mondo_queue_pkg::*;
   import mondo_iob_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      HDR1,
      DATA,
      ACK_WAIT,
      ERR0,
      ERR1
   } state_t;

   state_t              state;
   state_t              next_state;
   mrqq_entry_t         cur;
   makq_entry_t         result;
   logic                start;
   logic                resp;
   logic                ack_ff;
   logic                nack_ff;
   logic [ID_WIDTH-1:0] agent_id;
   logic [ID_WIDTH-1:0] cpu_id;

   assign cur = req.data;

   // Room for the result must exist before a request is taken
   assign start = (state == IDLE) && req.valid && !ack.full;
   assign resp  = ack_ff || nack_ff;

   always_comb begin
      case (state)
         IDLE:     next_state = start ? (cur.err ? ERR0 : HDR1) : IDLE;
         HDR1:     next_state = DATA;
         DATA:     next_state = last_beat ? ACK_WAIT : DATA;
         ACK_WAIT: next_state = resp ? IDLE : ACK_WAIT;
         ERR0:     next_state = ERR1;
         ERR1:     next_state = IDLE;
         default:  next_state = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= IDLE;
         ack_ff  <= 1'b0;
         nack_ff <= 1'b0;
      end else begin
         state   <= next_state;
         ack_ff  <= iob_ack;
         nack_ff <= iob_nack;
      end
   end

   // Ids outlive the request entry, which leaves before the bridge answers
   always_ff @(posedge clk) begin
      if (start) begin
         agent_id <= cur.agent_id;
         cpu_id   <= cur.cpu_id;
      end
   end

   // Error entries leave at once and sent ones on the last data select
   assign req.pop       = (start && cur.err) || ((state == DATA) && last_beat);
   assign credit_return = req.pop;

   always_comb begin
      case (state)
         IDLE:    beat_sel = (start && !cur.err) ? BEAT_CPU : BEAT_NONE;
         HDR1:    beat_sel = BEAT_AGENT;
         DATA:    beat_sel = BEAT_DATA;
         default: beat_sel = BEAT_NONE;
      endcase
   end

   // Counter back to zero for the next mondo
   assign cnt_clear   = (state == HDR1) || ((state == DATA) && last_beat);
   assign cnt_advance = (state == DATA) && !last_beat;

   always_comb begin
      result.nack     = (state == ERR0) ? 1'b1 : nack_ff;
      result.agent_id = agent_id;
      result.cpu_id   = cpu_id;
   end

   assign ack.push      = ((state == ACK_WAIT) && resp) || (state == ERR0);
   assign ack.push_data = result;

   // A bridge answer is only taken while a mondo waits for it
   assert property (@(posedge clk) disable iff (!rst_n)
      resp |-> (state == ACK_WAIT))
      else $error("%m: bridge response with no mondo in flight");

endmodule

// File: logic/mondo_capture.sv
`timescale 1ns/1ps

module mondo_capture (
   input logic                                 clk,
   input logic                                 rst_n,
   input logic                                 in_hdr_push,
   input logic                                 in_data_push,
   input logic                                 in_data_err,
   input logic [mondo_queue_pkg::AD_WIDTH-1:0] in_ad,
   queue_if.producer                           req
);

   import mondo_queue_pkg::*;

   logic [ID_WIDTH-1:0] agent_id;
   logic [ID_WIDTH-1:0] cpu_id;
   mrqq_entry_t         entry;

   // Ids come in the header cycle, payload one cycle later
   always_ff @(posedge clk) begin
      if (in_hdr_push) begin
         agent_id <= in_ad[AD_AGENT_ID_LO +: ID_WIDTH];
         cpu_id   <= in_ad[AD_CPU_ID_LO +: ID_WIDTH];
      end
   end

   always_comb begin
      entry.err      = in_data_err;
      entry.agent_id = agent_id;
      entry.cpu_id   = cpu_id;
      entry.data     = in_ad;
   end

   assign req.push      = in_data_push;
   assign req.push_data = entry;

   // Data cycle always directly behind its header
   assert property (@(posedge clk) disable iff (!rst_n)
      in_data_push |-> $past(in_hdr_push))
      else $error("%m: data push without a header one cycle before");

   // Sender overspent its credits
   assert property (@(posedge clk) disable iff (!rst_n)
      in_data_push |-> !req.full)
      else $error("%m: inbound mondo with no credit left");

endmodule

// File: logic/mondo_queue.sv
`timescale 1ns/1ps

module mondo_queue #(
   parameter type T     = logic,
   parameter int  DEPTH = 4
) (
   input logic      clk,
   input logic      rst_n,
   queue_if.storage q
);

   localparam int AW = $clog2(DEPTH);

   // Entry storage, flops only
   T mem [DEPTH];

   // Pointers carry one extra wrap bit
   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;

   logic [AW-1:0] wr_addr;
   logic [AW-1:0] rd_addr;

   assign wr_addr = wr_ptr[AW-1:0];
   assign rd_addr = rd_ptr[AW-1:0];

   // Same address, different lap means full
   assign q.full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_addr == rd_addr);
   assign q.valid = (wr_ptr != rd_ptr);
   assign q.data  = mem[rd_addr];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (q.push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (q.pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (q.push) begin
         mem[wr_addr] <= q.push_data;
      end
   end

   // Wrap-bit pointers need a power-of-two depth
   if (DEPTH != (1 << AW)) begin : g_depth_check
      $error("mondo_queue depth %0d is not a power of two", DEPTH);
   end

   // Overflow from the producer side
   assert property (@(posedge clk) disable iff (!rst_n)
      q.push |-> !q.full)
      else $error("%m: push into a full queue");

   // Underflow from the consumer side
   assert property (@(posedge clk) disable iff (!rst_n)
      q.pop |-> q.valid)
      else $error("%m: pop from an empty queue");

endmodule

// File: logic/queue_if.sv
`timescale 1ns/1ps

// Push/pop handshake between a queue and its producer and consumer
interface queue_if #(
   parameter type T = logic
) ();

   // Producer side
   logic push;
   T     push_data;
   logic full;

   // Consumer side, data is the head entry while valid is high
   logic valid;
   T     data;
   logic pop;

   modport producer (
      output push,
      output push_data,
      input  full
   );

   modport consumer (
      input  valid,
      input  data,
      output pop
   );

   modport storage (
      input  push,
      input  push_data,
      output full,
      output valid,
      output data,
      input  pop
   );

endinterface

// File: logic/mondo_iob_pkg.sv
// Mondo bus toward the I/O bridge
package mondo_iob_pkg;

   // Byte-wide mondo bus
   localparam int MONDO_BUS_WIDTH = 8;

   // Payload bytes sent after the two header beats
   localparam int DATA_BEATS = 16;

   // What the serializer drives on the next bus cycle
   typedef enum logic [1:0] {
      BEAT_NONE,
      BEAT_CPU,
      BEAT_AGENT,
      BEAT_DATA
   } beat_sel_t;

endpackage

// File: logic/mondo_queue_pkg.sv
// Queue entry formats and inbound bus layout for the mondo request path
package mondo_queue_pkg;

   // Id widths shared by the agent id and the CPU id
   localparam int ID_WIDTH = 5;

   // Inbound address/data bus and mondo payload
   localparam int AD_WIDTH = 128;

   // Id positions on the bus during the header cycle
   localparam int AD_CPU_ID_LO   = 0;
   localparam int AD_AGENT_ID_LO = 5;

   // Request queue depth, also the sender's initial credit count
   localparam int MRQQ_DEPTH = 8;

   // Acknowledge queue depth
   localparam int MAKQ_DEPTH = 4;

   // One inbound mondo as held in the request queue
   typedef struct packed {
      logic                err;
      logic [ID_WIDTH-1:0] agent_id;
      logic [ID_WIDTH-1:0] cpu_id;
      logic [AD_WIDTH-1:0] data;
   } mrqq_entry_t;

   // Result of one mondo, drained at the top level
   typedef struct packed {
      logic                nack;
      logic [ID_WIDTH-1:0] agent_id;
      logic [ID_WIDTH-1:0] cpu_id;
   } makq_entry_t;

endpackage
